//--- design/core_pkg.sv
package core_pkg;

	localparam int xlen       = 32;
	localparam int reg_count  = 16;
	localparam int reg_addr_w = 4;

	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_opimm  = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub  = 7'b0100000; // SUB only

	typedef enum logic [2:0] {
		op_lui,
		op_alui,
		op_alur,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_none
	} op_class_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

endpackage

//--- design/core_regfile.sv
`timescale 1ns/1ps

module core_regfile import core_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  wen,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [xlen-1:0]       wdata,
	input  logic [reg_addr_w-1:0] raddr1,
	input  logic [reg_addr_w-1:0] raddr2,
	output logic [xlen-1:0]       rdata1,
	output logic [xlen-1:0]       rdata2
);

	logic [xlen-1:0] regs [1:reg_count-1]; // No storage behind x0

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/core_ifu.sv
`timescale 1ns/1ps

module core_ifu import core_pkg::*; (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            wb_valid,
	input  logic [xlen-1:0] next_pc,
	input  logic            ibus_arready,
	input  logic [xlen-1:0] ibus_rdata,
	input  logic            ibus_rvalid,
	input  logic            if_ready,
	output logic [xlen-1:0] ibus_araddr,
	output logic            ibus_arvalid,
	output logic            ibus_rready,
	output logic            if_valid,
	output logic [xlen-1:0] if_inst,
	output logic [xlen-1:0] if_pc
);

	typedef enum logic [1:0] {
		s_addr,
		s_data,
		s_wait
	} state_e;

	state_e          state;
	logic [xlen-1:0] pc;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= s_addr;
			pc       <= reset_pc;
			if_valid <= 1'b0;
		end else begin
			case (state)
				s_addr: if (ibus_arready) state <= s_data;
				s_data: if (ibus_rvalid) begin
					state    <= s_wait;
					if_valid <= 1'b1;
				end
				s_wait: if (wb_valid) begin // Previous instruction retired
					state <= s_addr;
					pc    <= next_pc;
				end
				default: state <= s_addr;
			endcase
			if (if_valid && if_ready)
				if_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_data && ibus_rvalid)
			if_inst <= ibus_rdata;
	end

	assign ibus_araddr  = pc;
	assign ibus_arvalid = (state == s_addr);
	assign ibus_rready  = (state == s_data);
	assign if_pc        = pc; // PC only moves on wb_valid

endmodule

//--- design/core_idu.sv
`timescale 1ns/1ps

module core_idu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  if_valid,
	input  logic [xlen-1:0]       if_inst,
	input  logic [xlen-1:0]       if_pc,
	input  logic                  id_ready,
	output logic                  if_ready,
	output logic                  id_valid,
	output op_class_e             id_class,
	output alu_op_e               id_alu_op,
	output logic [reg_addr_w-1:0] id_rs1,
	output logic [reg_addr_w-1:0] id_rs2,
	output logic [reg_addr_w-1:0] id_rd,
	output logic [xlen-1:0]       id_imm,
	output logic [xlen-1:0]       id_pc,
	output logic                  id_wen
);

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm;
	op_class_e             cls;
	alu_op_e               alu;

	assign opcode = if_inst[6:0];
	assign funct3 = if_inst[14:12];
	assign funct7 = if_inst[31:25];
	assign rd     = if_inst[10:7]; // RV32E has only 16 registers

	assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
	assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
	assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
	assign imm_u = {if_inst[31:12], 12'b0};
	assign imm_j = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20], if_inst[30:21], 1'b0};

	always_comb begin
		cls = op_none;
		alu = alu_add;
		imm = imm_i;
		case (opcode)
			opc_lui: begin
				cls = op_lui;
				alu = alu_pass_b;
				imm = imm_u;
			end
			opc_opimm: begin
				cls = op_alui;
				case (funct3)
					3'b000: alu = alu_add;
					3'b100: alu = alu_xor;
					3'b110: alu = alu_or;
					3'b111: alu = alu_and;
					default: cls = op_none;
				endcase
			end
			opc_op: begin
				cls = op_alur;
				case ({funct7, funct3})
					{f7_base, 3'b000}: alu = alu_add;
					{f7_sub, 3'b000}:  alu = alu_sub;
					{f7_base, 3'b100}: alu = alu_xor;
					{f7_base, 3'b110}: alu = alu_or;
					{f7_base, 3'b111}: alu = alu_and;
					default: cls = op_none;
				endcase
			end
			opc_load: cls = (funct3 == 3'b010) ? op_load : op_none;
			opc_store: begin
				cls = (funct3 == 3'b010) ? op_store : op_none;
				imm = imm_s;
			end
			opc_branch: begin
				// BEQ goes as alu_sub and BNE as alu_xor, which sets the compare sense in exu
				cls = (funct3[2:1] == 2'b00) ? op_branch : op_none;
				alu = funct3[0] ? alu_xor : alu_sub;
				imm = imm_b;
			end
			opc_jal: begin
				cls = op_jal;
				imm = imm_j;
			end
			default: cls = op_none;
		endcase
	end

	assign if_ready = !id_valid || id_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			id_valid <= 1'b0;
		else if (if_ready)
			id_valid <= if_valid;
	end

	always_ff @(posedge clock) begin
		if (if_valid && if_ready) begin
			id_class  <= cls;
			id_alu_op <= alu;
			id_rs1    <= if_inst[18:15];
			id_rs2    <= if_inst[23:20];
			id_rd     <= rd;
			id_imm    <= imm;
			id_pc     <= if_pc;
			id_wen    <= !(cls inside {op_store, op_branch, op_none}) && (rd != '0);
		end
	end

endmodule

//--- design/core_exu.sv
`timescale 1ns/1ps

module core_exu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  id_valid,
	input  op_class_e             id_class,
	input  alu_op_e               id_alu_op,
	input  logic [xlen-1:0]       id_imm,
	input  logic [xlen-1:0]       id_pc,
	input  logic [reg_addr_w-1:0] id_rd,
	input  logic                  id_wen,
	input  logic [xlen-1:0]       src1,
	input  logic [xlen-1:0]       src2,
	input  logic                  ex_ready,
	output logic                  id_ready,
	output logic                  ex_valid,
	output op_class_e             ex_class,
	output logic [xlen-1:0]       ex_result,
	output logic [xlen-1:0]       ex_store_data,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic                  ex_wen,
	output logic [xlen-1:0]       ex_pc,
	output logic [xlen-1:0]       ex_next_pc
);

	logic [xlen-1:0] opb;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] seq_pc;
	logic            taken;

	assign opb = (id_class inside {op_alur, op_branch}) ? src2 : id_imm;

	always_comb begin
		case (id_alu_op)
			alu_sub:    alu_out = src1 - opb;
			alu_and:    alu_out = src1 & opb;
			alu_or:     alu_out = src1 | opb;
			alu_xor:    alu_out = src1 ^ opb;
			alu_pass_b: alu_out = opb; // LUI
			default:    alu_out = src1 + opb; // Also the LW and SW address
		endcase
	end

	assign seq_pc = id_pc + 32'd4;
	assign taken  = (id_class == op_branch) &&
		((id_alu_op == alu_sub) ? (src1 == src2) : (src1 != src2));

	assign id_ready = !ex_valid || ex_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else if (id_ready)
			ex_valid <= id_valid;
	end

	always_ff @(posedge clock) begin
		if (id_valid && id_ready) begin
			ex_class      <= id_class;
			ex_result     <= (id_class == op_jal) ? seq_pc : alu_out;
			ex_store_data <= src2;
			ex_rd         <= id_rd;
			ex_wen        <= id_wen;
			ex_pc         <= id_pc;
			ex_next_pc    <= (taken || id_class == op_jal) ? id_pc + id_imm : seq_pc;
		end
	end

endmodule

//--- design/core_lsu.sv
`timescale 1ns/1ps

module core_lsu import core_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  ex_valid,
	input  op_class_e             ex_class,
	input  logic [xlen-1:0]       ex_result,
	input  logic [xlen-1:0]       ex_store_data,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic                  ex_wen,
	input  logic [xlen-1:0]       ex_pc,
	input  logic [xlen-1:0]       ex_next_pc,
	input  logic                  dbus_arready,
	input  logic [xlen-1:0]       dbus_rdata,
	input  logic                  dbus_rvalid,
	input  logic                  dbus_awready,
	input  logic                  dbus_wready,
	input  logic                  dbus_bvalid,
	output logic                  ex_ready,
	output logic [xlen-1:0]       dbus_araddr,
	output logic                  dbus_arvalid,
	output logic                  dbus_rready,
	output logic [xlen-1:0]       dbus_awaddr,
	output logic                  dbus_awvalid,
	output logic [xlen-1:0]       dbus_wdata,
	output logic                  dbus_wvalid,
	output logic                  dbus_bready,
	output logic                  wb_valid,
	output logic [xlen-1:0]       next_pc,
	output logic                  rf_wen,
	output logic [reg_addr_w-1:0] rf_waddr,
	output logic [xlen-1:0]       rf_wdata,
	output logic                  commit_valid,
	output logic [xlen-1:0]       commit_pc,
	output logic [reg_addr_w-1:0] commit_rd,
	output logic                  commit_wen,
	output logic [xlen-1:0]       commit_data
);

	typedef enum logic [2:0] {
		s_idle,
		s_rd_addr,
		s_rd_data,
		s_write,
		s_write_resp,
		s_commit
	} state_e;

	state_e          state;
	logic            aw_done;
	logic            w_done;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] store_data;
	logic            ex_fire;
	logic            no_mem;
	logic            load_done;

	assign ex_ready  = (state == s_idle);
	assign ex_fire   = ex_valid && ex_ready;
	assign no_mem    = !(ex_class inside {op_load, op_store});
	assign load_done = (state == s_rd_data) && dbus_rvalid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state        <= s_idle;
			aw_done      <= 1'b0;
			w_done       <= 1'b0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= 1'b0;
			case (state)
				s_idle: if (ex_valid) begin
					if (ex_class == op_load)
						state <= s_rd_addr;
					else if (ex_class == op_store)
						state <= s_write;
					else begin
						state        <= s_commit;
						commit_valid <= 1'b1;
					end
				end
				s_rd_addr: if (dbus_arready) state <= s_rd_data;
				s_rd_data: if (dbus_rvalid) begin
					state        <= s_commit;
					commit_valid <= 1'b1;
				end
				s_write: begin
					// Address and data may be accepted on different edges
					aw_done <= aw_done || dbus_awready;
					w_done  <= w_done || dbus_wready;
					if ((aw_done || dbus_awready) && (w_done || dbus_wready))
						state <= s_write_resp;
				end
				s_write_resp: if (dbus_bvalid) begin
					state        <= s_commit;
					commit_valid <= 1'b1;
					aw_done      <= 1'b0;
					w_done       <= 1'b0;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ex_fire) begin
			addr        <= ex_result;
			store_data  <= ex_store_data;
			commit_pc   <= ex_pc;
			commit_rd   <= ex_rd;
			commit_wen  <= ex_wen;
			commit_data <= ex_result;
			next_pc     <= ex_next_pc;
		end
		if (load_done)
			commit_data <= dbus_rdata;
	end

	// The write lands on the edge that raises commit_valid
	assign rf_wen   = (ex_fire && no_mem && ex_wen) || (load_done && commit_wen);
	assign rf_waddr = load_done ? commit_rd : ex_rd;
	assign rf_wdata = load_done ? dbus_rdata : ex_result;

	assign dbus_araddr  = addr;
	assign dbus_arvalid = (state == s_rd_addr);
	assign dbus_rready  = (state == s_rd_data);
	assign dbus_awaddr  = addr;
	assign dbus_awvalid = (state == s_write) && !aw_done;
	assign dbus_wdata   = store_data;
	assign dbus_wvalid  = (state == s_write) && !w_done;
	assign dbus_bready  = (state == s_write_resp);

	assign wb_valid = commit_valid;

endmodule

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,

	output logic [xlen-1:0]       ibus_araddr,
	output logic                  ibus_arvalid,
	input  logic                  ibus_arready,
	input  logic [xlen-1:0]       ibus_rdata,
	input  logic                  ibus_rvalid,
	output logic                  ibus_rready,

	output logic [xlen-1:0]       dbus_araddr,
	output logic                  dbus_arvalid,
	input  logic                  dbus_arready,
	input  logic [xlen-1:0]       dbus_rdata,
	input  logic                  dbus_rvalid,
	output logic                  dbus_rready,
	output logic [xlen-1:0]       dbus_awaddr,
	output logic                  dbus_awvalid,
	input  logic                  dbus_awready,
	output logic [xlen-1:0]       dbus_wdata,
	output logic                  dbus_wvalid,
	input  logic                  dbus_wready,
	input  logic                  dbus_bvalid,
	output logic                  dbus_bready,

	output logic                  commit_valid,
	output logic [xlen-1:0]       commit_pc,
	output logic [reg_addr_w-1:0] commit_rd,
	output logic                  commit_wen,
	output logic [xlen-1:0]       commit_data
);

	logic                  wb_valid;
	logic [xlen-1:0]       next_pc;

	logic                  if_valid;
	logic                  if_ready;
	logic [xlen-1:0]       if_inst;
	logic [xlen-1:0]       if_pc;

	logic                  id_valid;
	logic                  id_ready;
	op_class_e             id_class;
	alu_op_e               id_alu_op;
	logic [reg_addr_w-1:0] id_rs1;
	logic [reg_addr_w-1:0] id_rs2;
	logic [reg_addr_w-1:0] id_rd;
	logic [xlen-1:0]       id_imm;
	logic [xlen-1:0]       id_pc;
	logic                  id_wen;
	logic [xlen-1:0]       src1;
	logic [xlen-1:0]       src2;

	logic                  ex_valid;
	logic                  ex_ready;
	op_class_e             ex_class;
	logic [xlen-1:0]       ex_result;
	logic [xlen-1:0]       ex_store_data;
	logic [reg_addr_w-1:0] ex_rd;
	logic                  ex_wen;
	logic [xlen-1:0]       ex_pc;
	logic [xlen-1:0]       ex_next_pc;

	logic                  rf_wen;
	logic [reg_addr_w-1:0] rf_waddr;
	logic [xlen-1:0]       rf_wdata;

	// Stage ports share their names with the nets above
	core_ifu core_ifu_i (.*);
	core_idu core_idu_i (.*);
	core_exu core_exu_i (.*);
	core_lsu core_lsu_i (.*);

	core_regfile core_regfile_i (
		.clock  (clock),
		.arst_n (arst_n),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata),
		.raddr1 (id_rs1),
		.raddr2 (id_rs2),
		.rdata1 (src1),
		.rdata2 (src2)
	);

endmodule

//--- verification/core_chk.sv
`timescale 1ns/1ps

module core_chk import core_pkg::*; (
	input logic            clock,
	input logic            arst_n,
	input logic [xlen-1:0] ibus_araddr,
	input logic            ibus_arvalid,
	input logic            ibus_arready,
	input logic [xlen-1:0] dbus_araddr,
	input logic            dbus_arvalid,
	input logic            dbus_arready,
	input logic [xlen-1:0] dbus_awaddr,
	input logic            dbus_awvalid,
	input logic            dbus_awready,
	input logic [xlen-1:0] dbus_wdata,
	input logic            dbus_wvalid,
	input logic            dbus_wready,
	input logic            commit_valid
);

	int fail_count = 0; // Read by the testbench at the end of the run

	ibus_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
		ibus_arvalid && !ibus_arready |=> ibus_arvalid && $stable(ibus_araddr))
		else begin
			$error("ibus read address withdrawn or changed before arready");
			fail_count++;
		end

	dbus_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
		dbus_arvalid && !dbus_arready |=> dbus_arvalid && $stable(dbus_araddr))
		else begin
			$error("dbus read address withdrawn or changed before arready");
			fail_count++;
		end

	dbus_aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
		dbus_awvalid && !dbus_awready |=> dbus_awvalid && $stable(dbus_awaddr))
		else begin
			$error("dbus write address withdrawn or changed before awready");
			fail_count++;
		end

	dbus_w_hold: assert property (@(posedge clock) disable iff (!arst_n)
		dbus_wvalid && !dbus_wready |=> dbus_wvalid && $stable(dbus_wdata))
		else begin
			$error("dbus write data withdrawn or changed before wready");
			fail_count++;
		end

	// One retired instruction gives exactly one strobe
	commit_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		commit_valid |=> !commit_valid)
		else begin
			$error("commit_valid stayed high for more than one cycle");
			fail_count++;
		end

	read_write_excl: assert property (@(posedge clock) disable iff (!arst_n)
		!(dbus_arvalid && dbus_awvalid))
		else begin
			$error("dbus read and write address valid at the same time");
			fail_count++;
		end

endmodule

bind core_top core_chk core_chk_i (.*);

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

	localparam logic [xlen-1:0] halt_pc = 32'h0000_0078; // JAL to self
	localparam int timeout_cycles = 5000;

	logic                  clock;
	logic                  arst_n;
	logic [xlen-1:0]       ibus_araddr;
	logic                  ibus_arvalid;
	logic                  ibus_arready;
	logic [xlen-1:0]       ibus_rdata;
	logic                  ibus_rvalid;
	logic                  ibus_rready;
	logic [xlen-1:0]       dbus_araddr;
	logic                  dbus_arvalid;
	logic                  dbus_arready;
	logic [xlen-1:0]       dbus_rdata;
	logic                  dbus_rvalid;
	logic                  dbus_rready;
	logic [xlen-1:0]       dbus_awaddr;
	logic                  dbus_awvalid;
	logic                  dbus_awready;
	logic [xlen-1:0]       dbus_wdata;
	logic                  dbus_wvalid;
	logic                  dbus_wready;
	logic                  dbus_bvalid;
	logic                  dbus_bready;
	logic                  commit_valid;
	logic [xlen-1:0]       commit_pc;
	logic [reg_addr_w-1:0] commit_rd;
	logic                  commit_wen;
	logic [xlen-1:0]       commit_data;

	logic [xlen-1:0] mem [0:255];
	logic [xlen-1:0] ref_mem [0:255];
	logic [xlen-1:0] ref_regs [0:reg_count-1];
	logic [xlen-1:0] ref_pc;

	integer seed = 50;
	int     mismatches = 0;
	int     failures = 0;
	int     commits = 0;
	int     expected_commits = 0;
	logic   running = 1'b1;
	logic   halted = 1'b0;

	logic [xlen-1:0]       e_pc;
	logic [reg_addr_w-1:0] e_rd;
	logic                  e_wen;
	logic [xlen-1:0]       e_data;
	logic                  e_st;
	logic [xlen-1:0]       e_st_addr;
	logic [xlen-1:0]       e_st_data;

	int              i_wait;
	logic            i_data_phase;
	logic [xlen-1:0] i_addr;
	int              d_wait;
	logic            d_data_phase;
	logic [xlen-1:0] d_addr;
	int              aw_wait;
	int              w_wait;
	int              b_wait;
	logic            got_aw;
	logic            got_w;
	logic [xlen-1:0] wr_addr;
	logic [xlen-1:0] wr_data;

	core_top core_top_i (.*);

	always #20 clock = ~clock;

	function automatic int rand_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	function automatic logic [31:0] alu_imm_word(input int f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] alu_reg_word(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input int rs1, input int rs2, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch_word(input int f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] lui_word(input int rd, input int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] jal_word(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic load_program();
		for (int k = 0; k < 256; k++)
			mem[k] = 32'hc0de_0000 ^ (k << 2);
		mem[0]  = lui_word(1, 'h12345);
		mem[1]  = alu_imm_word(0, 2, 0, 5); // Loop counter
		mem[2]  = alu_imm_word(0, 3, 0, -1);
		mem[3]  = alu_imm_word(4, 4, 3, 'h0f0);
		mem[4]  = alu_imm_word(6, 5, 1, 'h678);
		mem[5]  = alu_imm_word(7, 6, 5, 'h0ff);
		mem[6]  = alu_reg_word(0, 0, 7, 5, 6);
		mem[7]  = alu_reg_word('h20, 0, 8, 6, 5); // SUB
		mem[8]  = alu_reg_word(0, 4, 9, 7, 8);
		mem[9]  = alu_reg_word(0, 6, 10, 9, 2);
		mem[10] = alu_reg_word(0, 7, 11, 10, 4);
		mem[11] = alu_imm_word(0, 0, 0, 7);
		mem[12] = alu_reg_word(0, 0, 0, 7, 8);
		mem[13] = alu_imm_word(0, 12, 0, 'h200); // Data area base
		mem[14] = store_word(12, 7, 0);
		mem[15] = load_word(13, 12, 0);
		mem[16] = store_word(12, 8, 4);
		mem[17] = load_word(14, 12, 4);
		mem[18] = branch_word(0, 13, 7, 8); // Taken, skips the next word
		mem[19] = alu_imm_word(0, 15, 0, 1);
		mem[20] = branch_word(1, 13, 7, 8);
		mem[21] = branch_word(0, 13, 14, 8);
		mem[22] = alu_reg_word(0, 0, 15, 15, 2);
		mem[23] = store_word(12, 15, 8);
		mem[24] = alu_imm_word(0, 2, 2, -1);
		mem[25] = branch_word(1, 2, 0, -12); // Back to word 22
		mem[26] = load_word(1, 12, 8);
		mem[27] = load_word(3, 12, 12); // Never stored, reads the fill pattern
		mem[28] = jal_word(5, 8);
		mem[29] = alu_imm_word(0, 6, 0, 3);
		mem[30] = jal_word(0, 0);
	endtask

	task automatic reset_model();
		for (int k = 0; k < 256; k++)
			ref_mem[k] = mem[k];
		for (int k = 0; k < reg_count; k++)
			ref_regs[k] = '0;
		ref_pc = reset_pc;
	endtask

	// Executes one instruction on the architectural model
	function automatic void iss_step(
		output logic [xlen-1:0]       pc_o,
		output logic [reg_addr_w-1:0] rd_o,
		output logic                  wen_o,
		output logic [xlen-1:0]       data_o,
		output logic                  st_o,
		output logic [xlen-1:0]       st_addr_o,
		output logic [xlen-1:0]       st_data_o
	);
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] addr;
		logic [31:0] npc;
		logic        wen;

		inst      = ref_mem[ref_pc[9:2]];
		a         = ref_regs[inst[18:15]];
		b         = ref_regs[inst[23:20]];
		imm_i     = {{20{inst[31]}}, inst[31:20]};
		imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		pc_o      = ref_pc;
		rd_o      = inst[10:7];
		data_o    = '0;
		st_o      = 1'b0;
		st_addr_o = '0;
		st_data_o = '0;
		wen       = 1'b0;
		npc       = ref_pc + 32'd4;
		case (inst[6:0])
			7'b0110111: begin
				wen    = 1'b1;
				data_o = {inst[31:12], 12'h000};
			end
			7'b0010011: begin
				wen = 1'b1;
				case (inst[14:12])
					3'b000: data_o = a + imm_i;
					3'b100: data_o = a ^ imm_i;
					3'b110: data_o = a | imm_i;
					3'b111: data_o = a & imm_i;
					default: wen = 1'b0;
				endcase
			end
			7'b0110011: begin
				wen = 1'b1;
				case ({inst[31:25], inst[14:12]})
					10'b0000000_000: data_o = a + b;
					10'b0100000_000: data_o = a - b;
					10'b0000000_100: data_o = a ^ b;
					10'b0000000_110: data_o = a | b;
					10'b0000000_111: data_o = a & b;
					default: wen = 1'b0;
				endcase
			end
			7'b0000011: if (inst[14:12] == 3'b010) begin
				addr   = a + imm_i;
				wen    = 1'b1;
				data_o = ref_mem[addr[9:2]];
			end
			7'b0100011: if (inst[14:12] == 3'b010) begin
				addr                = a + imm_s;
				st_o                = 1'b1;
				st_addr_o           = addr;
				st_data_o           = b;
				ref_mem[addr[9:2]]  = b;
			end
			7'b1100011: begin
				if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b))
					npc = ref_pc + imm_b;
			end
			7'b1101111: begin
				wen    = 1'b1;
				data_o = ref_pc + 32'd4;
				npc    = ref_pc + imm_j;
			end
			default: ; // Anything else retires as a no-op
		endcase
		wen_o = wen && (inst[11:7] != 5'd0);
		if (wen_o)
			ref_regs[inst[10:7]] = data_o;
		ref_pc = npc;
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		mismatches++;
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
	endtask

	// Instruction bus responder
	always @(posedge clock) begin
		if (!arst_n) begin
			ibus_arready <= 1'b0;
			ibus_rvalid  <= 1'b0;
			i_data_phase <= 1'b0;
			i_wait       <= 0;
		end else if (!i_data_phase) begin
			if (ibus_arvalid && ibus_arready) begin
				ibus_arready <= 1'b0;
				i_addr       <= ibus_araddr;
				i_data_phase <= 1'b1;
				i_wait       <= rand_delay();
			end else if (ibus_arvalid) begin
				if (i_wait == 0)
					ibus_arready <= 1'b1;
				else
					i_wait <= i_wait - 1;
			end
		end else if (ibus_rvalid && ibus_rready) begin
			ibus_rvalid  <= 1'b0;
			i_data_phase <= 1'b0;
			i_wait       <= rand_delay();
		end else if (!ibus_rvalid) begin
			if (i_wait == 0) begin
				ibus_rvalid <= 1'b1;
				ibus_rdata  <= mem[i_addr[9:2]];
			end else
				i_wait <= i_wait - 1;
		end
	end

	// Data bus read channel
	always @(posedge clock) begin
		if (!arst_n) begin
			dbus_arready <= 1'b0;
			dbus_rvalid  <= 1'b0;
			d_data_phase <= 1'b0;
			d_wait       <= 0;
		end else if (!d_data_phase) begin
			if (dbus_arvalid && dbus_arready) begin
				dbus_arready <= 1'b0;
				d_addr       <= dbus_araddr;
				d_data_phase <= 1'b1;
				d_wait       <= rand_delay();
			end else if (dbus_arvalid) begin
				if (d_wait == 0)
					dbus_arready <= 1'b1;
				else
					d_wait <= d_wait - 1;
			end
		end else if (dbus_rvalid && dbus_rready) begin
			dbus_rvalid  <= 1'b0;
			d_data_phase <= 1'b0;
			d_wait       <= rand_delay();
		end else if (!dbus_rvalid) begin
			if (d_wait == 0) begin
				dbus_rvalid <= 1'b1;
				dbus_rdata  <= mem[d_addr[9:2]];
			end else
				d_wait <= d_wait - 1;
		end
	end

	// Data bus write channel, address and data accepted independently
	always @(posedge clock) begin
		if (!arst_n) begin
			dbus_awready <= 1'b0;
			dbus_wready  <= 1'b0;
			dbus_bvalid  <= 1'b0;
			got_aw       <= 1'b0;
			got_w        <= 1'b0;
			aw_wait      <= 0;
			w_wait       <= 0;
			b_wait       <= 0;
		end else begin
			if (dbus_awvalid && dbus_awready) begin
				dbus_awready <= 1'b0;
				wr_addr      <= dbus_awaddr;
				got_aw       <= 1'b1;
				aw_wait      <= rand_delay();
			end else if (dbus_awvalid) begin
				if (aw_wait == 0)
					dbus_awready <= 1'b1;
				else
					aw_wait <= aw_wait - 1;
			end
			if (dbus_wvalid && dbus_wready) begin
				dbus_wready <= 1'b0;
				wr_data     <= dbus_wdata;
				got_w       <= 1'b1;
				w_wait      <= rand_delay();
			end else if (dbus_wvalid) begin
				if (w_wait == 0)
					dbus_wready <= 1'b1;
				else
					w_wait <= w_wait - 1;
			end
			if (dbus_bvalid && dbus_bready) begin
				dbus_bvalid <= 1'b0;
				b_wait      <= rand_delay();
			end else if (got_aw && got_w && !dbus_bvalid) begin
				if (b_wait == 0) begin
					dbus_bvalid         <= 1'b1;
					mem[wr_addr[9:2]]   <= wr_data;
					got_aw              <= 1'b0;
					got_w               <= 1'b0;
				end else
					b_wait <= b_wait - 1;
			end
		end
	end

	// Commit outputs settle after the rising edge, so they are compared on the falling one
	always @(negedge clock) begin
		if (arst_n && running && commit_valid) begin
			iss_step(e_pc, e_rd, e_wen, e_data, e_st, e_st_addr, e_st_data);
			if (commits == 0 && commit_pc !== reset_pc)
				note_mismatch("first_commit_pc", reset_pc, commit_pc);
			commits++;
			if (commit_pc !== e_pc)
				note_mismatch("commit_pc", e_pc, commit_pc);
			if (commit_wen !== e_wen)
				note_mismatch("commit_wen", e_wen, commit_wen);
			if (e_wen && commit_rd !== e_rd)
				note_mismatch("commit_rd", e_rd, commit_rd);
			if (e_wen && commit_data !== e_data)
				note_mismatch("commit_data", e_data, commit_data);
			if (e_st && wr_addr !== e_st_addr)
				note_mismatch("store_addr", e_st_addr, wr_addr);
			if (e_st && wr_data !== e_st_data)
				note_mismatch("store_data", e_st_data, wr_data);
			if (commit_pc == halt_pc) begin // The core itself reached the final jump
				running = 1'b0;
				halted  = 1'b1;
			end
		end
	end

	initial begin
		int cycles;

		load_program();
		// Dry run of the model to find how many instructions retire up to the final jump
		reset_model();
		do begin
			iss_step(e_pc, e_rd, e_wen, e_data, e_st, e_st_addr, e_st_data);
			expected_commits++;
		end while (e_pc != halt_pc && expected_commits < 1000);
		if (e_pc != halt_pc) begin
			failures++;
			$display("the reference model never reached the final jump");
		end
		reset_model();

		clock        = 1'b0;
		arst_n       = 1'b0;
		ibus_arready = 1'b0;
		ibus_rdata   = '0;
		ibus_rvalid  = 1'b0;
		dbus_arready = 1'b0;
		dbus_rdata   = '0;
		dbus_rvalid  = 1'b0;
		dbus_awready = 1'b0;
		dbus_wready  = 1'b0;
		dbus_bvalid  = 1'b0;
		repeat (8) @(posedge clock);
		arst_n <= 1'b1;

		cycles = 0;
		while (!halted && cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		if (!halted) begin
			failures++;
			$display("timeout: the core did not reach the final jump in %0d cycles",
				timeout_cycles);
		end else if (commits != expected_commits) begin
			mismatches++;
			$display("mismatch commit_count: expected %0d, actual %0d", expected_commits, commits);
		end

		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures, %0d commits",
			mismatches, failures, core_top_i.core_chk_i.fail_count, commits);
		if (mismatches == 0 && failures == 0 && core_top_i.core_chk_i.fail_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- src.f
design/core_pkg.sv
design/core_regfile.sv
design/core_ifu.sv
design/core_idu.sv
design/core_exu.sv
design/core_lsu.sv
design/core_top.sv
verification/core_chk.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - design/core_pkg.sv
  - design/core_regfile.sv
  - design/core_ifu.sv
  - design/core_idu.sv
  - design/core_exu.sv
  - design/core_lsu.sv
  - design/core_top.sv
  - target: test
    files:
      - verification/core_chk.sv
      - verification/core_tb.sv
